// File: common/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

`define XLEN        32
`define REG_COUNT   32
`define RESET_PC    32'h8000_0000
`define INSTR_NOP   32'h0000_0013   // addi x0, x0, 0

// instruction field positions
`define F_OPCODE    6:0
`define F_RD        11:7
`define F_FUNCT3    14:12
`define F_RS1       19:15
`define F_RS2       24:20
`define F_FUNCT7    31:25

`endif

// File: common/rv_pkg.sv
`default_nettype none

`include "rv_params.svh"

package rv_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`XLEN-1:0] addr_t;
    typedef logic [31:0]      instr_t;   // fixed 32-bit encoding, not XLEN
    typedef logic [4:0]       reg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B   // lui
    } alu_op_e;

    // source of a decode operand
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EXE,
        FWD_WB
    } fwd_sel_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JAL
    } branch_e;

endpackage

`default_nettype wire

// File: hw/fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_params.svh"

module fetch_stage (
    input  logic              clock,
    input  logic              arst_n,
    input  logic              flush,
    input  logic              redirect,
    input  rv_pkg::addr_t     redirect_pc,
    output rv_pkg::addr_t     imem_addr,
    input  rv_pkg::instr_t    imem_data,
    output logic              d_valid,
    output rv_pkg::addr_t     d_pc,
    output rv_pkg::instr_t    d_instr
);

    rv_pkg::addr_t pc;
    rv_pkg::addr_t next_pc;

    assign imem_addr = pc;
    assign next_pc   = redirect ? redirect_pc : pc + rv_pkg::addr_t'(4);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc      <= `RESET_PC;
            d_valid <= 1'b0;
        end else begin
            pc      <= next_pc;
            d_valid <= !flush;   // wrong-path fetch dies here
        end
    end

    // fetch-to-decode payload
    always_ff @(posedge clock) begin
        d_pc    <= pc;
        d_instr <= flush ? `INSTR_NOP : imem_data;
    end

    // branch targets come back from execute, pc must stay on word grid
    a_pc_aligned : assert property (@(posedge clock) disable iff (!arst_n)
        imem_addr[1:0] == 2'b00)
        else $error("imem_addr %h not word aligned", imem_addr);

endmodule

`default_nettype wire

// File: decode/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_params.svh"

module reg_file (
    input  logic               clock,
    input  logic               arst_n,
    input  rv_pkg::reg_idx_t   rs1,
    input  rv_pkg::reg_idx_t   rs2,
    output rv_pkg::word_t      rf_a,
    output rv_pkg::word_t      rf_b,
    input  logic               w_valid,
    input  logic               w_wen,
    input  rv_pkg::reg_idx_t   w_rd,
    input  rv_pkg::word_t      w_data
);

    rv_pkg::word_t regs [`REG_COUNT];
    logic          wr_en;

    assign wr_en = w_valid && w_wen && (w_rd != '0);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[w_rd] <= w_data;
        end
    end

    // same-cycle write shows through to the readers
    assign rf_a = (rs1 == '0) ? '0 : (wr_en && w_rd == rs1) ? w_data : regs[rs1];
    assign rf_b = (rs2 == '0) ? '0 : (wr_en && w_rd == rs2) ? w_data : regs[rs2];

endmodule

`default_nettype wire

// File: decode/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_params.svh"

module decode_stage (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               flush,
    input  logic               d_valid,
    input  rv_pkg::addr_t      d_pc,
    input  rv_pkg::instr_t     d_instr,
    output rv_pkg::reg_idx_t   rs1,
    output rv_pkg::reg_idx_t   rs2,
    input  rv_pkg::word_t      rf_a,
    input  rv_pkg::word_t      rf_b,
    input  rv_pkg::fwd_sel_e   fwd_a,
    input  rv_pkg::fwd_sel_e   fwd_b,
    input  rv_pkg::word_t      exe_result,
    input  rv_pkg::word_t      w_data,
    output logic               e_valid,
    output rv_pkg::addr_t      e_pc,
    output rv_pkg::word_t      e_op_a,
    output rv_pkg::word_t      e_op_b,
    output rv_pkg::word_t      e_imm,
    output rv_pkg::alu_op_e    e_alu_op,
    output rv_pkg::branch_e    e_branch,
    output rv_pkg::reg_idx_t   e_rd,
    output logic               e_wen
);

    logic              dec_ok;
    logic              use_imm;
    logic              writes_rd;
    rv_pkg::alu_op_e   alu_op;
    rv_pkg::branch_e   branch;
    rv_pkg::word_t     imm;
    rv_pkg::word_t     op_a;
    rv_pkg::word_t     op_b;
    rv_pkg::reg_idx_t  rd;
    logic              keep;

    function automatic rv_pkg::word_t fwd_mux(input rv_pkg::fwd_sel_e sel,
                                              input rv_pkg::word_t rf_val,
                                              input rv_pkg::word_t exe_val,
                                              input rv_pkg::word_t wb_val);
        case (sel)
            rv_pkg::FWD_EXE: return exe_val;
            rv_pkg::FWD_WB:  return wb_val;
            default:         return rf_val;
        endcase
    endfunction

    assign rs1 = d_instr[`F_RS1];
    assign rs2 = d_instr[`F_RS2];
    assign rd  = d_instr[`F_RD];

    // ------------------------------------------------------------------------
    // instruction decode
    // ------------------------------------------------------------------------
    always_comb begin
        dec_ok    = 1'b0;
        use_imm   = 1'b0;
        writes_rd = 1'b0;
        alu_op    = rv_pkg::ALU_ADD;
        branch    = rv_pkg::BR_NONE;
        imm       = {{20{d_instr[31]}}, d_instr[31:20]};   // I-type by default
        case (d_instr[`F_OPCODE])
            7'b0110011: begin                              // register ALU ops
                writes_rd = 1'b1;
                dec_ok    = 1'b1;
                case ({d_instr[`F_FUNCT7], d_instr[`F_FUNCT3]})
                    10'b0000000_000: alu_op = rv_pkg::ALU_ADD;
                    10'b0100000_000: alu_op = rv_pkg::ALU_SUB;
                    10'b0000000_111: alu_op = rv_pkg::ALU_AND;
                    10'b0000000_110: alu_op = rv_pkg::ALU_OR;
                    10'b0000000_100: alu_op = rv_pkg::ALU_XOR;
                    10'b0000000_010: alu_op = rv_pkg::ALU_SLT;
                    default:         dec_ok = 1'b0;
                endcase
            end
            7'b0010011: begin                              // addi only
                dec_ok    = (d_instr[`F_FUNCT3] == 3'b000);
                use_imm   = 1'b1;
                writes_rd = 1'b1;
            end
            7'b0110111: begin                              // lui
                dec_ok    = 1'b1;
                use_imm   = 1'b1;
                writes_rd = 1'b1;
                alu_op    = rv_pkg::ALU_PASS_B;
                imm       = {d_instr[31:12], 12'b0};
            end
            7'b1100011: begin                              // beq / bne
                dec_ok = (d_instr[`F_FUNCT3] == 3'b000) || (d_instr[`F_FUNCT3] == 3'b001);
                branch = d_instr[12] ? rv_pkg::BR_NE : rv_pkg::BR_EQ;
                imm    = {{19{d_instr[31]}}, d_instr[31], d_instr[7],
                          d_instr[30:25], d_instr[11:8], 1'b0};
            end
            7'b1101111: begin                              // jal, link value made in execute
                dec_ok    = 1'b1;
                writes_rd = 1'b1;
                branch    = rv_pkg::BR_JAL;
                imm       = {{11{d_instr[31]}}, d_instr[31], d_instr[19:12],
                             d_instr[20], d_instr[30:21], 1'b0};
            end
            default: dec_ok = 1'b0;
        endcase
    end

    assign op_a = fwd_mux(fwd_a, rf_a, exe_result, w_data);
    assign op_b = use_imm ? imm : fwd_mux(fwd_b, rf_b, exe_result, w_data);
    assign keep = d_valid && dec_ok && !flush;

    // decode-to-execute control
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            e_valid  <= 1'b0;
            e_wen    <= 1'b0;
            e_branch <= rv_pkg::BR_NONE;
        end else begin
            e_valid  <= keep;
            e_wen    <= keep && writes_rd && (rd != '0);   // x0 target is a no-op
            e_branch <= keep ? branch : rv_pkg::BR_NONE;
        end
    end

    always_ff @(posedge clock) begin
        e_pc     <= d_pc;
        e_op_a   <= op_a;
        e_op_b   <= op_b;
        e_imm    <= imm;
        e_alu_op <= alu_op;
        e_rd     <= rd;
    end

    // execute result only feeds an operand from a live writer with a real destination
    a_fwd_exe_writer : assert property (@(posedge clock) disable iff (!arst_n)
        (fwd_a == rv_pkg::FWD_EXE || fwd_b == rv_pkg::FWD_EXE) |-> (e_wen && e_rd != '0))
        else $error("execute result forwarded from an instruction without a destination");

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               e_valid,
    input  rv_pkg::addr_t      e_pc,
    input  rv_pkg::word_t      e_op_a,
    input  rv_pkg::word_t      e_op_b,
    input  rv_pkg::word_t      e_imm,
    input  rv_pkg::alu_op_e    e_alu_op,
    input  rv_pkg::branch_e    e_branch,
    input  rv_pkg::reg_idx_t   e_rd,
    input  logic               e_wen,
    output rv_pkg::word_t      exe_result,
    output logic               redirect,
    output rv_pkg::addr_t      redirect_pc,
    output logic               w_valid,
    output rv_pkg::reg_idx_t   w_rd,
    output logic               w_wen,
    output rv_pkg::word_t      w_data,
    output rv_pkg::addr_t      commit_pc,
    output rv_pkg::addr_t      commit_next_pc
);

    rv_pkg::word_t alu_out;
    rv_pkg::addr_t pc_plus4;
    rv_pkg::addr_t target;
    rv_pkg::addr_t next_pc;
    logic          taken;

    // ------------------------------------------------------------------------
    // alu and branch resolution
    // ------------------------------------------------------------------------
    always_comb begin
        case (e_alu_op)
            rv_pkg::ALU_SUB:    alu_out = e_op_a - e_op_b;
            rv_pkg::ALU_AND:    alu_out = e_op_a & e_op_b;
            rv_pkg::ALU_OR:     alu_out = e_op_a | e_op_b;
            rv_pkg::ALU_XOR:    alu_out = e_op_a ^ e_op_b;
            rv_pkg::ALU_SLT:    alu_out = rv_pkg::word_t'($signed(e_op_a) < $signed(e_op_b));
            rv_pkg::ALU_PASS_B: alu_out = e_op_b;
            default:            alu_out = e_op_a + e_op_b;
        endcase
    end

    always_comb begin
        case (e_branch)
            rv_pkg::BR_EQ:  taken = (e_op_a == e_op_b);
            rv_pkg::BR_NE:  taken = (e_op_a != e_op_b);
            rv_pkg::BR_JAL: taken = 1'b1;
            default:        taken = 1'b0;
        endcase
    end

    assign pc_plus4    = e_pc + rv_pkg::addr_t'(4);
    assign target      = e_pc + e_imm;
    assign next_pc     = taken ? target : pc_plus4;
    assign exe_result  = (e_branch == rv_pkg::BR_JAL) ? pc_plus4 : alu_out;   // link value
    assign redirect    = e_valid && taken;
    assign redirect_pc = target;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            w_valid <= 1'b0;
            w_wen   <= 1'b0;
        end else begin
            w_valid <= e_valid;
            w_wen   <= e_valid && e_wen;
        end
    end

    // write-back payload, rd and data read as zero when nothing is written
    always_ff @(posedge clock) begin
        w_rd           <= e_wen ? e_rd : '0;
        w_data         <= e_wen ? exe_result : '0;
        commit_pc      <= e_pc;
        commit_next_pc <= next_pc;
    end

endmodule

`default_nettype wire

// File: hw/hazard_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_ctrl (
    input  logic               e_valid,
    input  logic               e_wen,
    input  rv_pkg::reg_idx_t   e_rd,
    input  logic               w_valid,
    input  logic               w_wen,
    input  rv_pkg::reg_idx_t   w_rd,
    input  rv_pkg::reg_idx_t   rs1,
    input  rv_pkg::reg_idx_t   rs2,
    input  logic               redirect,
    output rv_pkg::fwd_sel_e   fwd_a,
    output rv_pkg::fwd_sel_e   fwd_b,
    output logic               flush
);

    logic exe_hit_a;
    logic exe_hit_b;
    logic wb_hit_a;
    logic wb_hit_b;

    // a match only counts for a live, writing, nonzero destination
    assign exe_hit_a = e_valid && e_wen && (e_rd != '0) && (e_rd == rs1);
    assign exe_hit_b = e_valid && e_wen && (e_rd != '0) && (e_rd == rs2);
    assign wb_hit_a  = w_valid && w_wen && (w_rd != '0) && (w_rd == rs1);
    assign wb_hit_b  = w_valid && w_wen && (w_rd != '0) && (w_rd == rs2);

    // youngest producer wins
    assign fwd_a = exe_hit_a ? rv_pkg::FWD_EXE : wb_hit_a ? rv_pkg::FWD_WB : rv_pkg::FWD_REG;
    assign fwd_b = exe_hit_b ? rv_pkg::FWD_EXE : wb_hit_b ? rv_pkg::FWD_WB : rv_pkg::FWD_REG;

    // taken branch or jal in execute kills decode and fetch
    assign flush = redirect;

    always_comb begin
        a_flush_live : assert #0 (!flush || e_valid)
            else $error("flush raised by a bubble in execute");
    end

endmodule

`default_nettype wire

// File: hw/rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core (
    input  logic               clock,
    input  logic               arst_n,
    output rv_pkg::addr_t      imem_addr,
    input  rv_pkg::instr_t     imem_data,
    output logic               commit,
    output rv_pkg::addr_t      commit_pc,
    output rv_pkg::addr_t      commit_next_pc,
    output rv_pkg::reg_idx_t   commit_rd,
    output rv_pkg::word_t      commit_data
);

    // fetch to decode
    logic              d_valid;
    rv_pkg::addr_t     d_pc;
    rv_pkg::instr_t    d_instr;

    // operand read and forwarding
    rv_pkg::reg_idx_t  rs1;
    rv_pkg::reg_idx_t  rs2;
    rv_pkg::word_t     rf_a;
    rv_pkg::word_t     rf_b;
    rv_pkg::fwd_sel_e  fwd_a;
    rv_pkg::fwd_sel_e  fwd_b;

    // decode to execute
    logic              e_valid;
    rv_pkg::addr_t     e_pc;
    rv_pkg::word_t     e_op_a;
    rv_pkg::word_t     e_op_b;
    rv_pkg::word_t     e_imm;
    rv_pkg::alu_op_e   e_alu_op;
    rv_pkg::branch_e   e_branch;
    rv_pkg::reg_idx_t  e_rd;
    logic              e_wen;

    // execute results and write-back
    rv_pkg::word_t     exe_result;
    logic              redirect;
    rv_pkg::addr_t     redirect_pc;
    logic              flush;
    logic              w_valid;
    rv_pkg::reg_idx_t  w_rd;
    logic              w_wen;
    rv_pkg::word_t     w_data;

    fetch_stage u_fetch (
        .clock       (clock),
        .arst_n      (arst_n),
        .flush       (flush),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .d_valid     (d_valid),
        .d_pc        (d_pc),
        .d_instr     (d_instr)
    );

    decode_stage u_decode (
        .clock      (clock),
        .arst_n     (arst_n),
        .flush      (flush),
        .d_valid    (d_valid),
        .d_pc       (d_pc),
        .d_instr    (d_instr),
        .rs1        (rs1),
        .rs2        (rs2),
        .rf_a       (rf_a),
        .rf_b       (rf_b),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .exe_result (exe_result),
        .w_data     (w_data),
        .e_valid    (e_valid),
        .e_pc       (e_pc),
        .e_op_a     (e_op_a),
        .e_op_b     (e_op_b),
        .e_imm      (e_imm),
        .e_alu_op   (e_alu_op),
        .e_branch   (e_branch),
        .e_rd       (e_rd),
        .e_wen      (e_wen)
    );

    reg_file u_reg_file (
        .clock   (clock),
        .arst_n  (arst_n),
        .rs1     (rs1),
        .rs2     (rs2),
        .rf_a    (rf_a),
        .rf_b    (rf_b),
        .w_valid (w_valid),
        .w_wen   (w_wen),
        .w_rd    (w_rd),
        .w_data  (w_data)
    );

    execute_stage u_execute (
        .clock          (clock),
        .arst_n         (arst_n),
        .e_valid        (e_valid),
        .e_pc           (e_pc),
        .e_op_a         (e_op_a),
        .e_op_b         (e_op_b),
        .e_imm          (e_imm),
        .e_alu_op       (e_alu_op),
        .e_branch       (e_branch),
        .e_rd           (e_rd),
        .e_wen          (e_wen),
        .exe_result     (exe_result),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .w_valid        (w_valid),
        .w_rd           (w_rd),
        .w_wen          (w_wen),
        .w_data         (w_data),
        .commit_pc      (commit_pc),
        .commit_next_pc (commit_next_pc)
    );

    hazard_ctrl u_hazard (
        .e_valid  (e_valid),
        .e_wen    (e_wen),
        .e_rd     (e_rd),
        .w_valid  (w_valid),
        .w_wen    (w_wen),
        .w_rd     (w_rd),
        .rs1      (rs1),
        .rs2      (rs2),
        .redirect (redirect),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b),
        .flush    (flush)
    );

    // difftest commit port, straight off the write-back register
    assign commit      = w_valid;
    assign commit_rd   = w_rd;
    assign commit_data = w_data;

endmodule

`default_nettype wire

// File: verification/tb_rv_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_params.svh"

module tb_rv_core #(
    parameter logic [31:0] seed = 32'hfb1c_30e2
);

    localparam int period       = 20;
    localparam int reset_cycles = 8;
    localparam int prog_words   = 256;
    localparam int commit_goal  = 2000;

    logic              clock;
    logic              arst_n;
    rv_pkg::addr_t     imem_addr;
    rv_pkg::instr_t    imem_data;
    logic              commit;
    rv_pkg::addr_t     commit_pc;
    rv_pkg::addr_t     commit_next_pc;
    rv_pkg::reg_idx_t  commit_rd;
    rv_pkg::word_t     commit_data;

    rv_pkg::instr_t    prog [prog_words];
    rv_pkg::addr_t     fetch_offs;
    rv_pkg::word_t     model_regs [`REG_COUNT];
    rv_pkg::addr_t     model_pc;
    rv_pkg::addr_t     exp_next;
    rv_pkg::reg_idx_t  exp_rd;
    rv_pkg::word_t     exp_data;
    int                commits;

    rv_core dut (
        .clock          (clock),
        .arst_n         (arst_n),
        .imem_addr      (imem_addr),
        .imem_data      (imem_data),
        .commit         (commit),
        .commit_pc      (commit_pc),
        .commit_next_pc (commit_next_pc),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data)
    );

    // combinational instruction memory, nop outside the program
    assign fetch_offs = imem_addr - `RESET_PC;
    assign imem_data  = (fetch_offs < 32'(prog_words * 4)) ? prog[fetch_offs[9:2]] : `INSTR_NOP;

    // ------------------------------------------------------------------------
    // instruction encoders
    // ------------------------------------------------------------------------
    function automatic rv_pkg::instr_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                              input rv_pkg::reg_idx_t rd,
                                              input rv_pkg::reg_idx_t rs1,
                                              input rv_pkg::reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic rv_pkg::instr_t b_type(input logic [12:0] off, input logic [2:0] f3,
                                              input rv_pkg::reg_idx_t rs1,
                                              input rv_pkg::reg_idx_t rs2);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic rv_pkg::instr_t j_type(input logic [20:0] off,
                                              input rv_pkg::reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic fill_program();
        int unsigned       kind;
        int                tgt;
        rv_pkg::reg_idx_t  rd;
        rv_pkg::reg_idx_t  rs1;
        rv_pkg::reg_idx_t  rs2;
        for (int i = 0; i < prog_words - 1; i++) begin
            kind = $urandom_range(0, 9);
            rd   = 5'($urandom_range(0, 7));   // few registers, many dependencies
            rs1  = 5'($urandom_range(0, 7));
            rs2  = 5'($urandom_range(0, 7));
            case (kind)
                0: prog[i] = r_type(7'h00, 3'b000, rd, rs1, rs2);   // add
                1: prog[i] = r_type(7'h20, 3'b000, rd, rs1, rs2);   // sub
                2: prog[i] = r_type(7'h00, 3'b111, rd, rs1, rs2);
                3: prog[i] = r_type(7'h00, 3'b110, rd, rs1, rs2);
                4: prog[i] = r_type(7'h00, 3'b100, rd, rs1, rs2);
                5: prog[i] = r_type(7'h00, 3'b010, rd, rs1, rs2);   // slt
                6: prog[i] = {12'($urandom), rs1, 3'b000, rd, 7'b0010011};   // addi
                7: prog[i] = {20'($urandom), rd, 7'b0110111};                // lui
                8: begin                   // beq or bne, anywhere but itself
                    do begin
                        tgt = int'($urandom_range(0, prog_words - 1));
                    end while (tgt == i);
                    prog[i] = b_type(13'((tgt - i) * 4), {2'b00, 1'($urandom)}, rs1, rs2);
                end
                default: begin             // jal forward only
                    tgt     = int'($urandom_range(i + 1, prog_words - 1));
                    prog[i] = j_type(21'((tgt - i) * 4), rd);
                end
            endcase
        end
        prog[prog_words - 1] = j_type(21'd0, 5'd0);   // park on jal 0
    endtask

    // ------------------------------------------------------------------------
    // reference model and error reporting
    // ------------------------------------------------------------------------
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        $display("TEST FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic model_step(output rv_pkg::addr_t next_pc, output rv_pkg::reg_idx_t rd,
                              output rv_pkg::word_t data);
        rv_pkg::addr_t  offs;
        rv_pkg::instr_t ins;
        rv_pkg::word_t  a;
        rv_pkg::word_t  b;
        rv_pkg::word_t  res;
        logic           wr;
        offs    = model_pc - `RESET_PC;
        ins     = prog[offs[9:2]];
        a       = model_regs[ins[19:15]];
        b       = model_regs[ins[24:20]];
        next_pc = model_pc + 32'd4;
        wr      = 1'b1;
        res     = '0;
        case (ins[6:0])
            7'b0110011: begin
                case ({ins[31:25], ins[14:12]})
                    10'b0000000_000: res = a + b;
                    10'b0100000_000: res = a - b;
                    10'b0000000_111: res = a & b;
                    10'b0000000_110: res = a | b;
                    10'b0000000_100: res = a ^ b;
                    default:         res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                endcase
            end
            7'b0010011: res = a + {{20{ins[31]}}, ins[31:20]};
            7'b0110111: res = {ins[31:12], 12'h000};
            7'b1100011: begin
                wr = 1'b0;
                if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b)) begin
                    next_pc = model_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                          ins[11:8], 1'b0};
                end
            end
            7'b1101111: begin
                res     = model_pc + 32'd4;
                next_pc = model_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                      ins[30:21], 1'b0};
            end
            default: report_failure("reference model fetched an unsupported instruction");
        endcase
        rd   = wr ? ins[11:7] : 5'd0;
        data = (rd != 5'd0) ? res : '0;   // x0 writes vanish
        if (rd != 5'd0) begin
            model_regs[rd] = res;
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    initial begin
        arst_n = 1'b0;
        void'($urandom(seed));
        fill_program();
        repeat (reset_cycles) @(posedge clock);
        arst_n <= 1'b1;
    end

    initial begin
        #((reset_cycles + 4 * commit_goal) * period);
        $display("watchdog expired, core stopped committing after %0d commits", commits);
        $display("TEST FAILED");
        $fatal(1, "watchdog timeout");
    end

    // commit outputs are settled by the falling edge
    always @(negedge clock) begin
        if (!arst_n) begin
            model_pc = `RESET_PC;
            commits  = 0;
            for (int i = 0; i < `REG_COUNT; i++) begin
                model_regs[i] = '0;
            end
            assert (!commit) else report_failure("commit strobe seen while in reset");
        end else if (commit) begin
            if (commits == 0) begin
                assert (commit_pc == `RESET_PC)
                    else report_mismatch("first_commit_pc", `RESET_PC, commit_pc);
            end
            assert (commit_pc == model_pc)
                else report_mismatch("commit_pc", model_pc, commit_pc);
            model_step(exp_next, exp_rd, exp_data);
            assert (commit_next_pc == exp_next)
                else report_mismatch("commit_next_pc", exp_next, commit_next_pc);
            assert (commit_rd == exp_rd)
                else report_mismatch("commit_rd", 32'(exp_rd), 32'(commit_rd));
            assert (commit_data == exp_data)
                else report_mismatch("commit_data", exp_data, commit_data);
            model_pc = exp_next;
            commits  = commits + 1;
            if (commits == commit_goal) begin
                $display("TEST OK");
                $finish;
            end
        end
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+common
common/rv_pkg.sv
hw/fetch_stage.sv
decode/reg_file.sv
decode/decode_stage.sv
hw/execute_stage.sv
hw/hazard_ctrl.sv
hw/rv_core.sv
verification/tb_rv_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
SEED      ?= 32'hfb1c_30e2
FILE_LIST ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILE_LIST))
HDRS := $(wildcard common/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) "-Gseed=$(SEED)" -f $(FILE_LIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@! grep -q "TEST FAILED" $(LOG)
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
